//--- src/soc_bus_pkg.sv
// Shared bus constants and types for the SoC bus fabric; imported by every RTL block
package soc_bus_pkg;

    // Bus geometry
    localparam int data_width = 16;
    localparam int addr_width = 19; // Word address, byte address bits 19:1

    // I/O port map (byte addresses)
    localparam logic [15:0] leds_port         = 16'hFFFE;
    localparam logic [15:0] boot_ctrl_port    = 16'hFFEC;
    localparam logic [15:0] timer_reload_port = 16'h0040;
    localparam logic [15:0] timer_ctrl_port   = 16'h0042;

    // Top 16 KB of the 1 MB space
    localparam logic [addr_width-1:0] boot_window_base = 19'h7E000;

    // Decoded I/O target
    typedef enum logic [1:0] {
        io_none,
        io_leds,
        io_boot_ctrl,
        io_timer
    } io_target_e;

    typedef enum logic {
        timer_idle,
        timer_counting
    } timer_state_e;

endpackage

//--- src/io_decoder.sv
// I/O port decoder; turns a master I/O access into one register block select
`timescale 1ns/1ps

module io_decoder (
    input  logic [soc_bus_pkg::addr_width-1:0] addr,
    input  logic                               access,
    input  logic                               d_io,
    output logic                               leds_sel,
    output logic                               boot_ctrl_sel,
    output logic                               timer_sel,
    output logic                               default_sel
);
    import soc_bus_pkg::*;

    logic [15:0] port;
    logic        io_active;
    io_target_e  target;

    assign port      = {addr[14:0], 1'b0}; // Back to a byte port address
    assign io_active = access & d_io;

    always_comb begin
        case (port)
            leds_port:         target = io_leds;
            boot_ctrl_port:    target = io_boot_ctrl;
            timer_reload_port: target = io_timer;
            timer_ctrl_port:   target = io_timer;
            default:           target = io_none;
        endcase
    end

    // Exactly one select per I/O access
    always_comb begin
        leds_sel      = 1'b0;
        boot_ctrl_sel = 1'b0;
        timer_sel     = 1'b0;
        default_sel   = 1'b0;

        if (io_active) begin
            case (target)
                io_leds:      leds_sel = 1'b1;
                io_boot_ctrl: boot_ctrl_sel = 1'b1;
                io_timer:     timer_sel = 1'b1;
                default:      default_sel = 1'b1; // Unmapped, acked by bus_response
            endcase
        end
    end

endmodule

//--- src/mem_decoder.sv
// Memory decoder; routes a memory access to boot RAM or main RAM
`timescale 1ns/1ps

module mem_decoder (
    input  logic [soc_bus_pkg::addr_width-1:0] addr,
    input  logic                               access,
    input  logic                               d_io,
    input  logic                               boot_en,
    output logic                               boot_ram_sel,
    output logic                               main_ram_sel
);
    import soc_bus_pkg::*;

    logic mem_active;
    logic in_window;

    assign mem_active = access & ~d_io;
    assign in_window  = addr >= boot_window_base;

    always_comb begin
        boot_ram_sel = 1'b0;
        main_ram_sel = 1'b0;

        if (mem_active) begin
            if (boot_en && in_window)
                boot_ram_sel = 1'b1;
            else
                main_ram_sel = 1'b1; // Window falls through once boot is off
        end
    end

endmodule

//--- src/leds_register.sv
// LED output register on the I/O bus; written and read back by the CPU
`timescale 1ns/1ps

module leds_register #(
    parameter int num_leds = 8
) (
    input  logic                              sys_clk,
    input  logic                              rst,
    input  logic                              sel,
    input  logic                              wr_en,
    input  logic [soc_bus_pkg::data_width-1:0] wdata,
    output logic [soc_bus_pkg::data_width-1:0] rdata,
    output logic                              ack,
    output logic [num_leds-1:0]               leds
);
    import soc_bus_pkg::*;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ack  <= 1'b0;
            leds <= '0;
        end else begin
            ack <= sel & ~ack; // One ack per access
            if (sel && !ack && wr_en)
                leds <= wdata[num_leds-1:0];
        end
    end

    always_comb begin
        rdata = '0;
        if (ack)
            rdata[num_leds-1:0] = leds;
    end

endmodule

//--- src/boot_control_register.sv
// Boot control register; bit 0 maps the boot RAM over the top of memory
`timescale 1ns/1ps

module boot_control_register (
    input  logic                              sys_clk,
    input  logic                              rst,
    input  logic                              sel,
    input  logic                              wr_en,
    input  logic [soc_bus_pkg::data_width-1:0] wdata,
    output logic [soc_bus_pkg::data_width-1:0] rdata,
    output logic                              ack,
    output logic                              boot_en
);
    import soc_bus_pkg::*;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ack     <= 1'b0;
            boot_en <= 1'b1; // Boot from boot RAM out of reset
        end else begin
            ack <= sel & ~ack;
            if (sel && !ack && wr_en)
                boot_en <= wdata[0];
        end
    end

    assign rdata = ack ? {{(data_width - 1){1'b0}}, boot_en} : '0;

endmodule

//--- src/interval_timer.sv
// Interval timer; prescaled reloadable down-counter with a sticky interrupt
`timescale 1ns/1ps

module interval_timer #(
    parameter int timer_prescale = 4
) (
    input  logic                              sys_clk,
    input  logic                              rst,
    input  logic                              sel,
    input  logic                              reg_sel,
    input  logic                              wr_en,
    input  logic [soc_bus_pkg::data_width-1:0] wdata,
    output logic [soc_bus_pkg::data_width-1:0] rdata,
    output logic                              ack,
    output logic                              intr
);
    import soc_bus_pkg::*;

    localparam int pw = (timer_prescale > 1) ? $clog2(timer_prescale) : 1;
    localparam logic [pw-1:0] prescale_last = pw'(timer_prescale - 1);

    timer_state_e          state;
    logic [data_width-1:0] reload;
    logic [data_width-1:0] count;
    logic [pw-1:0]         prescale;
    logic                  do_write;
    logic                  tick;
    logic                  enable;

    assign do_write = sel & ~ack & wr_en;
    assign enable   = state == timer_counting;
    assign tick     = enable && prescale == prescale_last;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ack      <= 1'b0;
            state    <= timer_idle;
            reload   <= '0;
            count    <= '0;
            prescale <= '0;
            intr     <= 1'b0;
        end else begin
            ack <= sel & ~ack;

            if (enable)
                prescale <= tick ? '0 : prescale + 1'b1;

            if (tick) begin
                if (count == '0) begin
                    count <= reload; // Wrap and flag
                    intr  <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end

            if (do_write && !reg_sel) begin
                reload   <= wdata;
                count    <= wdata; // Restart so count stays within reload
                prescale <= '0;
            end

            if (do_write && reg_sel) begin
                if (wdata[0] && state == timer_idle) begin
                    count    <= reload;
                    prescale <= '0;
                end
                state <= wdata[0] ? timer_counting : timer_idle;
                if (wdata[1])
                    intr <= 1'b0; // Clear beats a same-cycle set
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (ack)
            rdata = reg_sel ? {{(data_width - 2){1'b0}}, intr, enable} : count;
    end

endmodule

//--- src/word_ram.sv
// Byte-writable synchronous word RAM with a one-cycle ack; used for boot and main RAM
`timescale 1ns/1ps

module word_ram #(
    parameter int words = 1024
) (
    input  logic                               sys_clk,
    input  logic                               sel,
    input  logic                               wr_en,
    input  logic [1:0]                         bytesel,
    input  logic [soc_bus_pkg::addr_width-1:0] addr,
    input  logic [soc_bus_pkg::data_width-1:0] wdata,
    output logic [soc_bus_pkg::data_width-1:0] rdata,
    output logic                               ack
);
    import soc_bus_pkg::*;

    localparam int aw = $clog2(words);

    logic [data_width-1:0] mem [words];
    logic [data_width-1:0] rdata_q;
    logic [aw-1:0]         index;
    logic                  start;

    assign index = addr[aw-1:0]; // Wraps modulo words
    assign start = sel & ~ack;

    initial begin
        for (int i = 0; i < words; i++)
            mem[i] = '0;
    end

    // High for one cycle per access
    always_ff @(posedge sys_clk)
        ack <= start;

    always_ff @(posedge sys_clk) begin
        if (start) begin
            if (wr_en && bytesel[0])
                mem[index][7:0] <= wdata[7:0];
            if (wr_en && bytesel[1])
                mem[index][15:8] <= wdata[15:8];
            rdata_q <= mem[index];
        end
    end

    assign rdata = ack ? rdata_q : '0;

endmodule

//--- src/bus_response.sv
// Response stage; merges block acks and read data back onto the master port
`timescale 1ns/1ps

module bus_response (
    input  logic                               sys_clk,
    input  logic                               rst,
    input  logic                               default_sel,
    input  logic                               leds_ack,
    input  logic [soc_bus_pkg::data_width-1:0] leds_rdata,
    input  logic                               boot_ctrl_ack,
    input  logic [soc_bus_pkg::data_width-1:0] boot_ctrl_rdata,
    input  logic                               timer_ack,
    input  logic [soc_bus_pkg::data_width-1:0] timer_rdata,
    input  logic                               boot_ram_ack,
    input  logic [soc_bus_pkg::data_width-1:0] boot_ram_rdata,
    input  logic                               main_ram_ack,
    input  logic [soc_bus_pkg::data_width-1:0] main_ram_rdata,
    input  logic                               io_data_sel,
    output logic [soc_bus_pkg::data_width-1:0] data_m_data_in,
    output logic                               data_m_ack
);
    import soc_bus_pkg::*;

    logic                  default_ack;
    logic [data_width-1:0] io_data;
    logic [data_width-1:0] mem_data;

    // Unclaimed I/O still gets an ack, data stays 0
    always_ff @(posedge sys_clk) begin
        if (rst)
            default_ack <= 1'b0;
        else
            default_ack <= default_sel & ~default_ack;
    end

    // Idle blocks drive zero, so OR is enough
    assign io_data  = leds_rdata | boot_ctrl_rdata | timer_rdata;
    assign mem_data = boot_ram_rdata | main_ram_rdata;

    assign data_m_data_in = io_data_sel ? io_data : mem_data;
    assign data_m_ack     = leds_ack | boot_ctrl_ack | timer_ack | default_ack |
                            boot_ram_ack | main_ram_ack;

endmodule

//--- src/soc_bus_top.sv
// Bus fabric top; connects the data master to decoders, register blocks and RAMs
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int num_leds       = 8,
    parameter int main_ram_words = 4096,
    parameter int boot_ram_words = 1024,
    parameter int timer_prescale = 4
) (
    input  logic                               sys_clk,
    input  logic                               rst,
    input  logic [soc_bus_pkg::addr_width-1:0] data_m_addr,
    input  logic [soc_bus_pkg::data_width-1:0] data_m_data_out,
    output logic [soc_bus_pkg::data_width-1:0] data_m_data_in,
    input  logic                               data_m_access,
    output logic                               data_m_ack,
    input  logic                               data_m_wr_en,
    input  logic [1:0]                         data_m_bytesel,
    input  logic                               d_io,
    output logic [num_leds-1:0]                leds,
    output logic                               intr
);
    import soc_bus_pkg::*;

    logic                  leds_sel, boot_ctrl_sel, timer_sel, default_sel;
    logic                  boot_ram_sel, main_ram_sel;
    logic                  boot_en;
    logic                  leds_ack, boot_ctrl_ack, timer_ack, boot_ram_ack, main_ram_ack;
    logic [data_width-1:0] leds_rdata, boot_ctrl_rdata, timer_rdata;
    logic [data_width-1:0] boot_ram_rdata, main_ram_rdata;

    io_decoder io_decoder0 (
        .addr(data_m_addr), .access(data_m_access), .d_io(d_io),
        .leds_sel(leds_sel), .boot_ctrl_sel(boot_ctrl_sel),
        .timer_sel(timer_sel), .default_sel(default_sel)
    );

    mem_decoder mem_decoder0 (
        .addr(data_m_addr), .access(data_m_access), .d_io(d_io), .boot_en(boot_en),
        .boot_ram_sel(boot_ram_sel), .main_ram_sel(main_ram_sel)
    );

    leds_register #(.num_leds(num_leds)) leds_register0 (
        .sys_clk(sys_clk), .rst(rst), .sel(leds_sel), .wr_en(data_m_wr_en),
        .wdata(data_m_data_out), .rdata(leds_rdata), .ack(leds_ack), .leds(leds)
    );

    boot_control_register boot_control_register0 (
        .sys_clk(sys_clk), .rst(rst), .sel(boot_ctrl_sel), .wr_en(data_m_wr_en),
        .wdata(data_m_data_out), .rdata(boot_ctrl_rdata), .ack(boot_ctrl_ack),
        .boot_en(boot_en)
    );

    // Byte address bit 1 picks reload or control
    interval_timer #(.timer_prescale(timer_prescale)) interval_timer0 (
        .sys_clk(sys_clk), .rst(rst), .sel(timer_sel), .reg_sel(data_m_addr[0]),
        .wr_en(data_m_wr_en), .wdata(data_m_data_out), .rdata(timer_rdata),
        .ack(timer_ack), .intr(intr)
    );

    word_ram #(.words(boot_ram_words)) boot_ram0 (
        .sys_clk(sys_clk), .sel(boot_ram_sel), .wr_en(data_m_wr_en),
        .bytesel(data_m_bytesel), .addr(data_m_addr), .wdata(data_m_data_out),
        .rdata(boot_ram_rdata), .ack(boot_ram_ack)
    );

    word_ram #(.words(main_ram_words)) main_ram0 (
        .sys_clk(sys_clk), .sel(main_ram_sel), .wr_en(data_m_wr_en),
        .bytesel(data_m_bytesel), .addr(data_m_addr), .wdata(data_m_data_out),
        .rdata(main_ram_rdata), .ack(main_ram_ack)
    );

    bus_response bus_response0 (
        .sys_clk(sys_clk), .rst(rst), .default_sel(default_sel),
        .leds_ack(leds_ack), .leds_rdata(leds_rdata),
        .boot_ctrl_ack(boot_ctrl_ack), .boot_ctrl_rdata(boot_ctrl_rdata),
        .timer_ack(timer_ack), .timer_rdata(timer_rdata),
        .boot_ram_ack(boot_ram_ack), .boot_ram_rdata(boot_ram_rdata),
        .main_ram_ack(main_ram_ack), .main_ram_rdata(main_ram_rdata),
        .io_data_sel(d_io), .data_m_data_in(data_m_data_in), .data_m_ack(data_m_ack)
    );

endmodule

//--- verif/tb_checks.svh
// Compare tasks and CPU bus access tasks for the SoC bus testbench, included inside tb_soc_bus
`ifndef tb_checks_svh
`define tb_checks_svh

task automatic compare_data(input string name, input logic [data_width-1:0] expected,
                            input logic [data_width-1:0] actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("error %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
    end
endtask

task automatic compare_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("error %s: expected %b, actual %b", name, expected, actual);
    end
endtask

// One master access; ack is due on the first edge after access rises
task automatic bus_access(input string name, input logic io, input logic wr,
                          input logic [addr_width-1:0] addr,
                          input logic [data_width-1:0] wdata, input logic [1:0] bytesel,
                          output logic [data_width-1:0] rdata);
    int   cycles;
    logic acked;
    cycles = 0;
    acked  = 1'b0;
    rdata  = '0;
    @(posedge sys_clk);
    #1;
    compare_bit($sformatf("%s ack idle before access", name), 1'b0, data_m_ack);
    data_m_addr     = addr;
    data_m_data_out = wdata;
    data_m_wr_en    = wr;
    data_m_bytesel  = bytesel;
    d_io            = io;
    data_m_access   = 1'b1;
    while (!acked && cycles < ack_timeout) begin
        @(posedge sys_clk);
        #1; // Outputs settled after the edge
        cycles++;
        acked = data_m_ack;
    end
    if (acked) begin
        compare_bit($sformatf("%s ack in one cycle", name), 1'b1, cycles == 1);
        rdata = data_m_data_in;
    end else begin
        errors++;
        $display("%s: no ack within %0d cycles", name, ack_timeout);
    end
    data_m_access = 1'b0; // Idle for at least one cycle
    data_m_wr_en  = 1'b0;
endtask

task automatic write_word(input string name, input logic io, input logic [addr_width-1:0] addr,
                          input logic [data_width-1:0] wdata, input logic [1:0] bytesel);
    logic [data_width-1:0] discard;
    bus_access(name, io, 1'b1, addr, wdata, bytesel, discard);
endtask

task automatic read_check(input string name, input logic io, input logic [addr_width-1:0] addr,
                          input logic [data_width-1:0] expected);
    logic [data_width-1:0] rdata;
    bus_access(name, io, 1'b0, addr, '0, 2'b11, rdata);
    compare_data(name, expected, rdata);
endtask

`endif

//--- verif/tb_soc_bus.sv
// Testbench for the SoC bus fabric; plays the CPU and checks every access against a model
`timescale 1ns/1ps

module tb_soc_bus;
    import soc_bus_pkg::*;

    localparam int num_leds       = 8;
    localparam int main_ram_words = 4096;
    localparam int boot_ram_words = 1024;
    localparam int timer_prescale = 4;
    localparam int ack_timeout    = 16;
    localparam logic [addr_width-1:0] leds_addr   = {4'b0, leds_port[15:1]};
    localparam logic [addr_width-1:0] boot_addr   = {4'b0, boot_ctrl_port[15:1]};
    localparam logic [addr_width-1:0] reload_addr = {4'b0, timer_reload_port[15:1]};
    localparam logic [addr_width-1:0] ctrl_addr   = {4'b0, timer_ctrl_port[15:1]};

    logic                  sys_clk, rst;
    logic [addr_width-1:0] data_m_addr;
    logic [data_width-1:0] data_m_data_out, data_m_data_in;
    logic                  data_m_access, data_m_ack, data_m_wr_en, d_io;
    logic [1:0]            data_m_bytesel;
    logic [num_leds-1:0]   leds;
    logic                  intr;

    int                    errors, checks, tests, errors_at_start;
    logic [15:0]           lfsr_state;
    logic [data_width-1:0] main_model [main_ram_words];
    logic [data_width-1:0] boot_model [boot_ram_words];
    logic                  boot_en_model;
    logic [num_leds-1:0]   leds_model;

    soc_bus_top #(
        .num_leds(num_leds), .main_ram_words(main_ram_words),
        .boot_ram_words(boot_ram_words), .timer_prescale(timer_prescale)
    ) dut0 (
        .sys_clk(sys_clk), .rst(rst), .data_m_addr(data_m_addr),
        .data_m_data_out(data_m_data_out), .data_m_data_in(data_m_data_in),
        .data_m_access(data_m_access), .data_m_ack(data_m_ack), .data_m_wr_en(data_m_wr_en),
        .data_m_bytesel(data_m_bytesel), .d_io(d_io), .leds(leds), .intr(intr)
    );

    `include "tb_checks.svh"

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [data_width-1:0] merge_bytes(input logic [data_width-1:0] old_word,
                                                          input logic [data_width-1:0] wdata,
                                                          input logic [1:0] bytesel);
        return {bytesel[1] ? wdata[15:8] : old_word[15:8],
                bytesel[0] ? wdata[7:0] : old_word[7:0]};
    endfunction

    function automatic logic in_boot_ram(input logic [addr_width-1:0] addr);
        return boot_en_model && addr >= boot_window_base;
    endfunction

    task automatic mem_write(input string name, input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] wdata, input logic [1:0] bytesel);
        int index;
        if (in_boot_ram(addr)) begin
            index             = addr % boot_ram_words;
            boot_model[index] = merge_bytes(boot_model[index], wdata, bytesel);
        end else begin
            index             = addr % main_ram_words;
            main_model[index] = merge_bytes(main_model[index], wdata, bytesel);
        end
        write_word(name, 1'b0, addr, wdata, bytesel);
    endtask

    task automatic mem_read(input string name, input logic [addr_width-1:0] addr);
        logic [data_width-1:0] expected;
        expected = in_boot_ram(addr) ? boot_model[addr % boot_ram_words]
                                     : main_model[addr % main_ram_words];
        read_check(name, 1'b0, addr, expected);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == errors_at_start)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic test_reset();
        compare_bit("reset ack", 1'b0, data_m_ack);
        compare_bit("reset intr", 1'b0, intr);
        compare_data("reset leds", '0, data_width'(leds));
        read_check("reset boot control", 1'b1, boot_addr, 16'h0001);
        read_check("reset timer control", 1'b1, ctrl_addr, 16'h0000);
        finish_test("reset");
    endtask

    task automatic test_main_ram();
        logic [addr_width-1:0] addr_list [$];
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic [1:0]            bytesel;
        for (int i = 0; i < 32; i++) begin
            addr     = addr_width'(take_bits(addr_width));
            addr[18] = 1'b0; // Below the boot window
            wdata    = data_width'(take_bits(data_width));
            bytesel  = 2'(take_bits(2));
            addr_list.push_back(addr);
            mem_write("main ram write", addr, wdata, bytesel);
        end
        // Odd reads use an alias one RAM size away
        foreach (addr_list[i]) begin
            addr = (i % 2 == 1) ? addr_list[i] ^ addr_width'(main_ram_words) : addr_list[i];
            mem_read("main ram read", addr);
        end
        finish_test("main ram");
    endtask

    task automatic test_boot_window();
        logic [addr_width-1:0] addr_list [$];
        logic [addr_width-1:0] addr;
        for (int i = 0; i < 8; i++) begin
            addr = boot_window_base + addr_width'(take_bits(13));
            addr_list.push_back(addr);
            mem_write("boot ram write", addr, data_width'(take_bits(data_width)), 2'b11);
        end
        foreach (addr_list[i])
            mem_read("boot ram read", addr_list[i]);
        write_word("boot control off", 1'b1, boot_addr, 16'h0000, 2'b11);
        boot_en_model = 1'b0;
        read_check("boot control read", 1'b1, boot_addr, 16'h0000);
        foreach (addr_list[i])
            mem_read("window main ram read", addr_list[i]);
        write_word("boot control on", 1'b1, boot_addr, 16'h0001, 2'b11);
        boot_en_model = 1'b1;
        foreach (addr_list[i])
            mem_read("boot ram reappears", addr_list[i]);
        finish_test("boot window");
    endtask

    task automatic test_leds();
        logic [data_width-1:0] wdata;
        for (int i = 0; i < 6; i++) begin
            wdata      = data_width'(take_bits(data_width));
            leds_model = wdata[num_leds-1:0];
            write_word("leds write", 1'b1, leds_addr, wdata, 2'b11);
            compare_data("leds output", data_width'(leds_model), data_width'(leds));
            read_check("leds read", 1'b1, leds_addr, data_width'(leds_model));
        end
        finish_test("leds");
    endtask

    task automatic test_unmapped_io();
        logic [addr_width-1:0] addr;
        logic [15:0]           port;
        for (int i = 0; i < 12; i++) begin
            addr = addr_width'(take_bits(addr_width));
            port = {addr[14:0], 1'b0};
            if (port == leds_port || port == boot_ctrl_port ||
                port == timer_reload_port || port == timer_ctrl_port)
                addr ^= addr_width'(16'h0100); // Port bit 9 moves it off the map
            if (take_bits(1) != 0)
                write_word("unmapped write", 1'b1, addr, data_width'(take_bits(16)), 2'b11);
            else
                read_check("unmapped read", 1'b1, addr, '0);
        end
        compare_data("leds after unmapped", data_width'(leds_model), data_width'(leds));
        read_check("leds read after unmapped", 1'b1, leds_addr, data_width'(leds_model));
        read_check("boot control after unmapped", 1'b1, boot_addr, data_width'(boot_en_model));
        read_check("timer count after unmapped", 1'b1, reload_addr, '0);
        read_check("timer control after unmapped", 1'b1, ctrl_addr, '0);
        finish_test("unmapped io");
    endtask

    task automatic test_timer();
        logic [data_width-1:0] reload;
        logic [data_width-1:0] rdata;
        int                    limit;
        int                    cycles;
        reload = data_width'(take_bits(5)) + 16'd2;
        limit  = (int'(reload) + 1) * timer_prescale + 4;
        write_word("timer reload write", 1'b1, reload_addr, reload, 2'b11);
        read_check("timer idle count", 1'b1, reload_addr, reload);
        write_word("timer enable", 1'b1, ctrl_addr, 16'h0001, 2'b11);
        cycles = 0;
        while (!intr && cycles < limit) begin
            @(posedge sys_clk);
            #1;
            cycles++;
        end
        checks++;
        if (!intr) begin
            errors++;
            $display("timer interrupt not raised within %0d cycles", limit);
        end
        for (int i = 0; i < 4; i++) begin
            bus_access("timer count read", 1'b1, 1'b0, reload_addr, '0, 2'b11, rdata);
            checks++;
            if (rdata > reload) begin
                errors++;
                $display("timer count 0x%04h is above the reload value 0x%04h", rdata, reload);
            end
        end
        read_check("timer control running", 1'b1, ctrl_addr, 16'h0003);
        write_word("timer clear", 1'b1, ctrl_addr, 16'h0002, 2'b11);
        compare_bit("timer intr cleared", 1'b0, intr);
        read_check("timer control cleared", 1'b1, ctrl_addr, 16'h0000);
        finish_test("timer");
    endtask

    initial begin
        rst             = 1'b1;
        data_m_addr     = '0;
        data_m_data_out = '0;
        data_m_access   = 1'b0;
        data_m_wr_en    = 1'b0;
        data_m_bytesel  = 2'b00;
        d_io            = 1'b0;
        errors          = 0;
        checks          = 0;
        tests           = 0;
        errors_at_start = 0;
        lfsr_state      = 16'd94;
        boot_en_model   = 1'b1;
        leds_model      = '0;
        foreach (main_model[i])
            main_model[i] = '0;
        foreach (boot_model[i])
            boot_model[i] = '0;
        repeat (10) @(posedge sys_clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_main_ram();
        test_boot_window();
        test_leds();
        test_unmapped_io();
        test_timer();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+verif
src/soc_bus_pkg.sv
src/io_decoder.sv
src/mem_decoder.sv
src/leds_register.sv
src/boot_control_register.sv
src/interval_timer.sv
src/word_ram.sv
src/bus_response.sv
src/soc_bus_top.sv
verif/tb_soc_bus.sv
